// ==== common/sfir_pkg.sv ====
package sfir_pkg;

    // sample and coefficient widths
    localparam int SAMPLE_W  = 16;
    localparam int COEF_W    = 16;
    localparam int OUT_W     = 16;

    // one extra bit for the mirrored pre-add
    localparam int PREADD_W  = SAMPLE_W + 1;
    localparam int PRODUCT_W = PREADD_W + COEF_W;

    // cascade sum, enough headroom for up to 64 coefficient pairs
    localparam int ACC_W     = 40;

    // output clamp limits
    localparam int OUT_MAX   = (2 ** (OUT_W - 1)) - 1;
    localparam int OUT_MIN   = -(2 ** (OUT_W - 1));

    typedef logic signed [SAMPLE_W-1:0]  sample_t;
    typedef logic signed [COEF_W-1:0]    coef_t;
    typedef logic signed [PREADD_W-1:0]  preadd_t;
    typedef logic signed [PRODUCT_W-1:0] product_t;
    typedef logic signed [ACC_W-1:0]     acc_t;
    typedef logic signed [OUT_W-1:0]     out_t;

    // scaled output word with its valid level
    typedef struct packed {
        out_t y;
        logic valid;
    } sfir_out_s;

endpackage

// ==== design/sfir_tap_delay.sv ====
module sfir_tap_delay
    import sfir_pkg::*;
#(
    parameter int DEPTH = 8
) (
    input  logic    clk_i,
    input  logic    arst_n_i,
    input  logic    en_i,
    input  sample_t data_i,
    output sample_t data_o
);

    sample_t stage_q [DEPTH];

    // one stage per accepted sample
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 0; i < DEPTH; i++) begin
                stage_q[i] <= '0;
            end
        end else if (en_i) begin
            stage_q[0] <= data_i;
            for (int i = 1; i < DEPTH; i++) begin
                stage_q[i] <= stage_q[i-1];
            end
        end
    end

    // oldest sample feeds the mirrored half of every tap pair
    assign data_o = stage_q[DEPTH-1];

endmodule

// ==== sfir/sfir_systolic_element.sv ====
module sfir_systolic_element
    import sfir_pkg::*;
#(
    parameter coef_t COEF_VAL = '0
) (
    input  logic    clk_i,
    input  logic    arst_n_i,
    input  logic    en_i,
    input  sample_t datain_i,
    input  sample_t datazin_i,
    input  acc_t    cascin_i,
    output sample_t cascdata_o,
    output acc_t    cascout_o
);

    // forward sample path, two registers per element
    sample_t a0_q;
    sample_t a1_q;

    // mirrored sample from the shared delay line
    sample_t b0_q;

    // pre-add, product and cascade registers
    preadd_t  m_q;
    product_t p_q;
    acc_t     pout_q;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            a0_q <= '0;
            a1_q <= '0;
            b0_q <= '0;
        end else if (en_i) begin
            a0_q <= datain_i;
            a1_q <= a0_q;
            b0_q <= datazin_i;
        end
    end

    // both mirrored taps share one coefficient
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            m_q <= '0;
            p_q <= '0;
        end else if (en_i) begin
            m_q <= preadd_t'(a1_q) + preadd_t'(b0_q);
            p_q <= product_t'(m_q) * product_t'(COEF_VAL);
        end
    end

    // sign-extended product joins the running sum
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            pout_q <= '0;
        end else if (en_i) begin
            pout_q <= acc_t'(p_q) + cascin_i;
        end
    end

    // the twice-delayed sample moves on to the next element
    assign cascdata_o = a1_q;
    assign cascout_o  = pout_q;

endmodule

// ==== sfir/sfir_systolic_array.sv ====
module sfir_systolic_array
    import sfir_pkg::*;
#(
    parameter int    TAP_NUM       = 4,
    parameter coef_t COEF [TAP_NUM] = '{default: '0}
) (
    input  logic    clk_i,
    input  logic    arst_n_i,
    input  logic    en_i,
    input  sample_t data_i,
    output acc_t    acc_o
);

    localparam int DEPTH = 2 * TAP_NUM;

    sample_t mirror_data;
    sample_t tap_data [TAP_NUM];
    acc_t    tap_acc  [TAP_NUM];
    acc_t    sum_q;

    sfir_tap_delay #(
        .DEPTH(DEPTH)
    ) u_tap_delay (
        .clk_i   (clk_i),
        .arst_n_i(arst_n_i),
        .en_i    (en_i),
        .data_i  (data_i),
        .data_o  (mirror_data)
    );

    for (genvar i = 0; i < TAP_NUM; i++) begin : g_tap
        sample_t din;
        acc_t    cin;

        // first element starts the chain with an empty cascade
        if (i == 0) begin : g_first
            assign din = data_i;
            assign cin = '0;
        end else begin : g_next
            assign din = tap_data[i-1];
            assign cin = tap_acc[i-1];
        end

        sfir_systolic_element #(
            .COEF_VAL(COEF[i])
        ) u_element (
            .clk_i     (clk_i),
            .arst_n_i  (arst_n_i),
            .en_i      (en_i),
            .datain_i  (din),
            .datazin_i (mirror_data),
            .cascin_i  (cin),
            .cascdata_o(tap_data[i]),
            .cascout_o (tap_acc[i])
        );
    end

    // registered full-precision sum at the end of the cascade
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            sum_q <= '0;
        end else if (en_i) begin
            sum_q <= tap_acc[TAP_NUM-1];
        end
    end

    assign acc_o = sum_q;

endmodule

// ==== design/sfir_output_scale.sv ====
module sfir_output_scale
    import sfir_pkg::*;
#(
    parameter int TAP_NUM   = 4,
    parameter int OUT_SHIFT = 6
) (
    input  logic      clk_i,
    input  logic      arst_n_i,
    input  logic      en_i,
    input  acc_t      acc_i,
    output sfir_out_s out_o
);

    // first step whose output window holds only accepted samples
    localparam int LIMIT = 3 * TAP_NUM + 4;
    localparam int CNT_W = $clog2(LIMIT + 1);

    // half an output LSB, zero when there is no shift
    localparam longint RND = (longint'(1) << OUT_SHIFT) >> 1;

    typedef logic signed [ACC_W:0] wide_t;

    wide_t            shifted;
    out_t             y_next;
    out_t             y_q;
    logic             valid_q;
    logic [CNT_W-1:0] step_cnt_q;

    always_comb begin
        shifted = (wide_t'(acc_i) + wide_t'(RND)) >>> OUT_SHIFT;
        if (shifted > wide_t'(OUT_MAX)) begin
            y_next = out_t'(OUT_MAX);
        end else if (shifted < wide_t'(OUT_MIN)) begin
            y_next = out_t'(OUT_MIN);
        end else begin
            y_next = out_t'(shifted);
        end
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            y_q        <= '0;
            valid_q    <= 1'b0;
            step_cnt_q <= '0;
        end else if (en_i) begin
            y_q <= y_next;
            // counter parks at the limit, valid stays up until reset
            if (step_cnt_q != CNT_W'(LIMIT)) begin
                step_cnt_q <= step_cnt_q + 1'b1;
            end else begin
                valid_q <= 1'b1;
            end
        end
    end

    assign out_o = '{y: y_q, valid: valid_q};

endmodule

// ==== design/sfir_filter_top.sv ====
module sfir_filter_top
    import sfir_pkg::*;
#(
    parameter int    TAP_NUM        = 4,
    parameter coef_t COEF [TAP_NUM] = '{default: '0},
    parameter int    OUT_SHIFT      = 6
) (
    input  logic      clk_i,
    input  logic      arst_n_i,
    input  logic      en_i,
    input  sample_t   data_i,
    output sfir_out_s out_o
);

    // full-precision filter sum
    acc_t acc;

    sfir_systolic_array #(
        .TAP_NUM(TAP_NUM),
        .COEF   (COEF)
    ) u_array (
        .clk_i   (clk_i),
        .arst_n_i(arst_n_i),
        .en_i    (en_i),
        .data_i  (data_i),
        .acc_o   (acc)
    );

    sfir_output_scale #(
        .TAP_NUM  (TAP_NUM),
        .OUT_SHIFT(OUT_SHIFT)
    ) u_scale (
        .clk_i   (clk_i),
        .arst_n_i(arst_n_i),
        .en_i    (en_i),
        .acc_i   (acc),
        .out_o   (out_o)
    );

endmodule

// ==== verif/tb_sfir_model.svh ====
`ifndef TB_SFIR_MODEL_SVH
`define TB_SFIR_MODEL_SVH

// accepted samples since reset, oldest first
longint model_hist[$];
// mirrored tap table, 2*TAP_NUM entries
longint h_tab [2*TAP_NUM];
out_t   model_y;
logic   model_valid;

function automatic void model_init();
    model_hist.delete();
    for (int k = 0; k < 2 * TAP_NUM; k++) begin
        if (k < TAP_NUM) begin
            h_tab[k] = longint'(COEF[k]);
        end else begin
            h_tab[k] = longint'(COEF[2*TAP_NUM-1-k]);
        end
    end
    model_y     = '0;
    model_valid = 1'b0;
endfunction

// round half up, arithmetic shift, clamp to the output range
function automatic out_t scale_acc(input longint acc);
    longint v;
    v = acc;
    if (OUT_SHIFT > 0) begin
        v = v + (longint'(1) <<< (OUT_SHIFT - 1));
    end
    v = v >>> OUT_SHIFT;
    if (v > longint'(OUT_MAX)) begin
        v = longint'(OUT_MAX);
    end else if (v < longint'(OUT_MIN)) begin
        v = longint'(OUT_MIN);
    end
    return out_t'(v);
endfunction

// one accepted sample; output lags the input by TAP_NUM+5 steps
function automatic void model_accept(input sample_t x);
    longint acc;
    int     t;
    int     idx;
    model_hist.push_back(longint'(x));
    t   = model_hist.size() - 1;
    acc = 0;
    for (int k = 0; k < 2 * TAP_NUM; k++) begin
        idx = t - (TAP_NUM + 5) - k;
        if (idx >= 0) begin
            acc = acc + h_tab[k] * model_hist[idx];
        end
    end
    model_y     = scale_acc(acc);
    model_valid = (t >= 3 * TAP_NUM + 4);
endfunction

`endif

// ==== verif/tb_sfir.sv ====
module tb_sfir
    import sfir_pkg::*;
();

    localparam int    TAP_NUM        = 4;
    localparam coef_t COEF [TAP_NUM] = '{coef_t'(3), coef_t'(-17), coef_t'(120), coef_t'(511)};
    localparam int    OUT_SHIFT      = 6;

    localparam int IMPULSE_STEPS  = 3 * TAP_NUM + 8;
    localparam int RAND_STEPS     = 400;
    localparam int SAT_RUN        = 3 * TAP_NUM + 12;
    localparam int STIM_CYCLES    = 4 + 3 + IMPULSE_STEPS + RAND_STEPS + 2 * SAT_RUN + 4;
    localparam int TIMEOUT_CYCLES = 4 * STIM_CYCLES;

    logic      clk_i;
    logic      arst_n_i;
    logic      en_i;
    sample_t   data_i;
    sfir_out_s out_o;

    logic        [15:0] lfsr_q;
    logic               pend_en;
    sample_t            pend_data;
    int                 checks;
    int                 errors;
    int                 cycle_cnt = 0;

    `include "tb_sfir_model.svh"

    sfir_filter_top #(
        .TAP_NUM  (TAP_NUM),
        .COEF     (COEF),
        .OUT_SHIFT(OUT_SHIFT)
    ) i_dut (
        .clk_i   (clk_i),
        .arst_n_i(arst_n_i),
        .en_i    (en_i),
        .data_i  (data_i),
        .out_o   (out_o)
    );

    always #50 clk_i = ~clk_i;

    always @(posedge clk_i) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("SIMULATION FAILED");
            $finish;
        end
    end

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic lfsr_bit();
        logic fb;
        fb     = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
        lfsr_q = {lfsr_q[14:0], fb};
        return fb;
    endfunction

    function automatic logic [15:0] take_bits(input int n);
        logic [15:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r = {r[14:0], lfsr_bit()};
        end
        return r;
    endfunction

    task automatic check_value(input string name, input longint expected, input longint actual);
        checks++;
        if (expected != actual) begin
            errors++;
            $display("** Error [%s] expected %0d, actual %0d", name, expected, actual);
        end
    endtask

    task automatic apply_reset();
        @(posedge clk_i);
        arst_n_i <= 1'b0;
        en_i     <= 1'b0;
        data_i   <= '0;
        pend_en   = 1'b0;
        pend_data = '0;
        model_init();
        repeat (2) begin
            @(negedge clk_i);
            check_value("reset y", 0, longint'($signed(out_o.y)));
            check_value("reset valid", 0, longint'(out_o.valid));
            @(posedge clk_i);
        end
        arst_n_i <= 1'b1;
    endtask

    // the DUT takes the previous drive at this edge, outputs are read at the falling edge
    task automatic step(input logic en, input sample_t data, input string name);
        @(posedge clk_i);
        if (pend_en) begin
            model_accept(pend_data);
        end
        en_i     <= en;
        data_i   <= data;
        pend_en   = en;
        pend_data = data;
        @(negedge clk_i);
        check_value({name, " y"}, longint'(model_y), longint'($signed(out_o.y)));
        check_value({name, " valid"}, longint'(model_valid), longint'(out_o.valid));
    endtask

    initial begin
        clk_i    = 1'b0;
        arst_n_i = 1'b0;
        en_i     = 1'b0;
        data_i   = '0;
        lfsr_q   = 16'd42187;
        checks   = 0;
        errors   = 0;

        apply_reset();
        repeat (3) step(1'b0, sample_t'(0), "reset");

        // valid rises at step 3*TAP_NUM+4 of this run
        step(1'b1, sample_t'(256), "impulse");
        repeat (IMPULSE_STEPS) step(1'b1, sample_t'(0), "impulse");

        repeat (RAND_STEPS) begin
            step(take_bits(2) != 16'd0, sample_t'(take_bits(16)), "random");
        end

        repeat (SAT_RUN) step(1'b1, sample_t'(32767), "saturate");
        check_value("saturate max", longint'(OUT_MAX), longint'($signed(out_o.y)));
        repeat (SAT_RUN) step(1'b1, sample_t'(-32768), "saturate");
        check_value("saturate min", longint'(OUT_MIN), longint'($signed(out_o.y)));
        step(1'b0, sample_t'(0), "saturate");

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

// ==== compile.f ====
+incdir+verif
common/sfir_pkg.sv
design/sfir_tap_delay.sv
sfir/sfir_systolic_element.sv
sfir/sfir_systolic_array.sv
design/sfir_output_scale.sv
design/sfir_filter_top.sv
verif/tb_sfir.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the FIR testbench with Verilator
set -e

cd "$(dirname "$0")"

LOG=sim.log

rm -rf obj_dir
verilator --binary --timing --top-module tb_sfir -f compile.f

./obj_dir/Vtb_sfir > "$LOG" 2>&1
cat "$LOG"

if grep -q "SIMULATION FAILED" "$LOG"; then
    echo "testbench reported a failure"
    exit 1
fi

if ! grep -q "SIMULATION PASSED" "$LOG"; then
    echo "testbench ended without a result"
    exit 1
fi

exit 0
